//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINTFLAGS  ?= --lint-only -Wall --timing
TOP        := flow_mux_tb
FILELIST   := files.f
OBJDIR     := obj_dir
PASS_MSG   := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- files.f
+incdir+hdl
hdl/arb_types_pkg.sv
hdl/flow_types_pkg.sv
hdl/rr_arbiter.sv
hdl/flow_arb_core.sv
hdl/onehot_mux.sv
hdl/flow_mux_core.sv
hdl/flow_reg_stage.sv
hdl/flow_mux_top.sv
testbench/flow_mux_tb.sv

//--- hdl/arb_types_pkg.sv
// Arbitration-side types for per-flow vectors and flow indices

`include "flow_mux_defs.svh"

package arb_types_pkg;

  // ---------------------------------------------------------------------------
  // Per-flow bit vectors
  // ---------------------------------------------------------------------------

  // One bit per flow
  // Carries request, grant, valid and ready alike
  typedef logic [`FLOW_NUM_FLOWS-1:0] flowVec_t;

  // ---------------------------------------------------------------------------
  // Flow index
  // ---------------------------------------------------------------------------

  // Binary index of a single flow
  // Used for the priority pointer and for the source tag on the pop side
  typedef logic [`FLOW_IDX_WIDTH-1:0] flowIdx_t;

endpackage : arb_types_pkg

//--- hdl/flow_arb_core.sv
// Flow arbitration core mapping flow valids to requests and grants to readies

`include "flow_mux_defs.svh"

module flow_arb_core
  import arb_types_pkg::*;
(
  // Base arbiter side
  output flowVec_t request,
  input  flowVec_t canGrant,
  input  flowVec_t grant,
  output logic     enablePriorityUpdate,
  // Push side
  output flowVec_t pushReady,
  input  flowVec_t pushValid,
  // Pop side
  input  logic     popReady,
  output logic     popValidUnstable
);

  // ---------------------------------------------------------------------------
  // Request path
  // ---------------------------------------------------------------------------

  // Every valid flow asks for the pop side
  assign request = pushValid;

  // Pop side sees a valid whenever any flow offers
  assign popValidUnstable = |pushValid;

  // ---------------------------------------------------------------------------
  // Ready path
  // ---------------------------------------------------------------------------

  // Flow may transfer only if the arbiter would pick it
  // and the pop side can take the item this cycle
  assign pushReady = canGrant & {`FLOW_NUM_FLOWS{popReady}};

  // ---------------------------------------------------------------------------
  // Priority update
  // ---------------------------------------------------------------------------

  // Granted flow actually moved an item
  logic grantTaken;

  // Grant is one-hot, so a nonzero AND means the winner was valid
  assign grantTaken = |(grant & pushValid);

  // Rotate priority only on a real pop transfer
  assign enablePriorityUpdate = popValidUnstable && popReady && grantTaken;

endmodule : flow_arb_core

//--- hdl/flow_mux_core.sv
// Combinational flow mux joining the arbitration core and the one-hot data mux

`include "flow_mux_defs.svh"

module flow_mux_core
  import arb_types_pkg::*;
  import flow_types_pkg::*;
(
  // External base arbiter
  output flowVec_t        request,
  input  flowVec_t        canGrant,
  input  flowVec_t        grant,
  output logic            enablePriorityUpdate,
  // Push side
  output flowVec_t        pushReady,
  input  flowVec_t        pushValid,
  input  flowPayloadVec_t pushPayload,
  // Pop side, valid and item follow push inputs in the same cycle
  input  logic            popReady,
  output logic            popValidUnstable,
  output popItem_t        popItemUnstable
);

  // ---------------------------------------------------------------------------
  // Handshake control
  // ---------------------------------------------------------------------------

  flow_arb_core flowArbCore (
    .request              (request),
    .canGrant             (canGrant),
    .grant                (grant),
    .enablePriorityUpdate (enablePriorityUpdate),
    .pushReady            (pushReady),
    .pushValid            (pushValid),
    .popReady             (popReady),
    .popValidUnstable     (popValidUnstable)
  );

  // ---------------------------------------------------------------------------
  // Data steering
  // ---------------------------------------------------------------------------

  // Each payload stamped with its own flow number
  popItem_t [`FLOW_NUM_FLOWS-1:0] taggedItems;

  always_comb begin
    for (int i = 0; i < `FLOW_NUM_FLOWS; i++) begin
      taggedItems[i].source  = flowIdx_t'(i);
      taggedItems[i].payload = pushPayload[i];
    end
  end

  // Grant picks the winning tagged item
  onehot_mux #(
    .itemType (popItem_t)
  ) itemMux (
    .select (grant),
    .in     (taggedItems),
    .out    (popItemUnstable)
  );

endmodule : flow_mux_core

//--- hdl/flow_mux_defs.svh
// Flow mux sizing macros shared by the packages and the RTL blocks

`ifndef FLOW_MUX_DEFS_SVH
`define FLOW_MUX_DEFS_SVH

// ---------------------------------------------------------------------------
// Flow count
// ---------------------------------------------------------------------------

// Number of upstream flows merged onto the pop side
`define FLOW_NUM_FLOWS 4

// Bits needed to name one flow
`define FLOW_IDX_WIDTH 2

// ---------------------------------------------------------------------------
// Payload fields
// ---------------------------------------------------------------------------

// Data field of one payload
`define FLOW_DATA_WIDTH 16

// Tag field of one payload
`define FLOW_TAG_WIDTH 4

`endif

//--- hdl/flow_mux_top.sv
// Flow mux top with round-robin arbiter, mux core and registered pop stage

`include "flow_mux_defs.svh"

module flow_mux_top
  import arb_types_pkg::*;
  import flow_types_pkg::*;
(
  input  logic            clk,
  input  logic            arstN,
  // Push side, one handshake per flow
  input  flowVec_t        pushValid,
  output flowVec_t        pushReady,
  input  flowPayloadVec_t pushPayload,
  // Registered pop side
  output logic            popValid,
  input  logic            popReady,
  output popItem_t        popItem
);

  // ---------------------------------------------------------------------------
  // Internal wires
  // ---------------------------------------------------------------------------

  // Arbiter handshake
  flowVec_t arbRequest;
  flowVec_t arbGrant;
  flowVec_t arbCanGrant;
  logic     arbUpdate;

  // Core to register stage
  logic     coreValid;
  logic     coreReady;
  popItem_t coreItem;

  // ---------------------------------------------------------------------------
  // Arbiter
  // ---------------------------------------------------------------------------

  rr_arbiter rrArbiter (
    .clk                  (clk),
    .arstN                (arstN),
    .request              (arbRequest),
    .enablePriorityUpdate (arbUpdate),
    .grant                (arbGrant),
    .canGrant             (arbCanGrant)
  );

  // ---------------------------------------------------------------------------
  // Combinational mux
  // ---------------------------------------------------------------------------

  flow_mux_core flowMuxCore (
    .request              (arbRequest),
    .canGrant             (arbCanGrant),
    .grant                (arbGrant),
    .enablePriorityUpdate (arbUpdate),
    .pushReady            (pushReady),
    .pushValid            (pushValid),
    .pushPayload          (pushPayload),
    .popReady             (coreReady),
    .popValidUnstable     (coreValid),
    .popItemUnstable      (coreItem)
  );

  // ---------------------------------------------------------------------------
  // Pop register
  // ---------------------------------------------------------------------------

  // Holds the pop side steady under back-pressure
  flow_reg_stage #(
    .itemType (popItem_t)
  ) flowRegStage (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (coreValid),
    .inReady  (coreReady),
    .inItem   (coreItem),
    .outValid (popValid),
    .outReady (popReady),
    .outItem  (popItem)
  );

endmodule : flow_mux_top

//--- hdl/flow_reg_stage.sv
// Two-entry skid register stage giving a registered, stable valid/ready output

`include "flow_mux_defs.svh"

module flow_reg_stage #(
  // Any packed item type
  parameter type itemType = logic
) (
  input  logic    clk,
  input  logic    arstN,
  // Upstream side
  input  logic    inValid,
  output logic    inReady,
  input  itemType inItem,
  // Downstream side
  output logic    outValid,
  input  logic    outReady,
  output itemType outItem
);

  // ---------------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------------

  // Output entry drives the pop port directly
  logic    outValidQ;
  itemType outItemQ;

  // Skid entry catches one item while the output is stalled
  logic    skidValidQ;
  itemType skidItemQ;

  logic    pushFire;
  logic    loadOut;

  // Ready depends on fill level only
  // Low only when output and skid entries both hold items
  assign inReady  = !skidValidQ;
  assign pushFire = inValid && inReady;

  // Output entry is free this cycle if empty or being popped
  assign loadOut  = !outValidQ || outReady;

  // ---------------------------------------------------------------------------
  // Control state
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValidQ  <= 1'b0;
      skidValidQ <= 1'b0;
    end else if (loadOut) begin
      // Skid drains first, keeping arrival order
      outValidQ  <= skidValidQ || pushFire;
      skidValidQ <= 1'b0;
    end else if (pushFire) begin
      // Output stalled, park the new item
      skidValidQ <= 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // Payload registers
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (loadOut) begin
      outItemQ <= skidValidQ ? skidItemQ : inItem;
    end
    if (!loadOut && pushFire) begin
      skidItemQ <= inItem;
    end
  end

  assign outValid = outValidQ;
  assign outItem  = outItemQ;

endmodule : flow_reg_stage

//--- hdl/flow_types_pkg.sv
// Payload types for the push side and the tagged pop-side item

`include "flow_mux_defs.svh"

package flow_types_pkg;

  import arb_types_pkg::*;

  // ---------------------------------------------------------------------------
  // Push-side payload
  // ---------------------------------------------------------------------------

  // Tag sits in the upper bits, data below
  typedef struct packed {
    logic [`FLOW_TAG_WIDTH-1:0]  tag;
    logic [`FLOW_DATA_WIDTH-1:0] data;
  } flowPayload_t;

  // One payload slot per flow, index 0 in the low bits
  typedef flowPayload_t [`FLOW_NUM_FLOWS-1:0] flowPayloadVec_t;

  // ---------------------------------------------------------------------------
  // Pop-side item
  // ---------------------------------------------------------------------------

  // Payload plus the flow it came from
  typedef struct packed {
    flowIdx_t     source;
    flowPayload_t payload;
  } popItem_t;

endpackage : flow_types_pkg

//--- hdl/onehot_mux.sv
// One-hot select mux over one item per flow, item type set by parameter

`include "flow_mux_defs.svh"

module onehot_mux
  import arb_types_pkg::*;
#(
  // Any packed type works here
  parameter type itemType = logic
) (
  input  flowVec_t                         select,
  input  itemType [`FLOW_NUM_FLOWS-1:0]    in,
  output itemType                          out
);

  // ---------------------------------------------------------------------------
  // OR reduction
  // ---------------------------------------------------------------------------

  // Running OR of the selected entries
  itemType merged;

  // Each selected entry is ORed in
  // With a one-hot select only one entry survives
  // An all-zero select gives an all-zero item
  always_comb begin
    merged = '0;
    for (int i = 0; i < `FLOW_NUM_FLOWS; i++) begin
      if (select[i]) begin
        merged = itemType'(merged | in[i]);
      end
    end
  end

  assign out = merged;

endmodule : onehot_mux

//--- hdl/rr_arbiter.sv
// Round-robin base arbiter with a priority pointer that moves on enabled cycles

`include "flow_mux_defs.svh"

module rr_arbiter
  import arb_types_pkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  // Request and grant vectors
  input  flowVec_t request,
  input  logic     enablePriorityUpdate,
  output flowVec_t grant,
  output flowVec_t canGrant
);

  // ---------------------------------------------------------------------------
  // Priority state
  // ---------------------------------------------------------------------------

  // Most recently granted flow
  flowIdx_t priorityPtr;

  // Winner of the current cycle
  flowIdx_t winner;
  logic     anyWinner;
  flowVec_t winnerVec;

  // ---------------------------------------------------------------------------
  // Winner search
  // ---------------------------------------------------------------------------

  // Walk cyclically from the flow after the pointer
  // The pointer flow itself is checked last
  always_comb begin
    flowIdx_t cand;
    anyWinner = 1'b0;
    winner    = priorityPtr;
    winnerVec = '0;
    for (int off = 1; off <= `FLOW_NUM_FLOWS; off++) begin
      cand = flowIdx_t'((int'(priorityPtr) + off) % `FLOW_NUM_FLOWS);
      if (!anyWinner && request[cand]) begin
        anyWinner = 1'b1;
        winner    = cand;
      end
    end
    // One-hot grant, zero when nobody asks
    if (anyWinner) begin
      winnerVec[winner] = 1'b1;
    end
  end

  // Round-robin always grants when any flow requests
  // so the state-free grant and the real grant match
  assign grant    = winnerVec;
  assign canGrant = winnerVec;

  // ---------------------------------------------------------------------------
  // Pointer update
  // ---------------------------------------------------------------------------

  // Reset to the last flow so flow 0 wins first
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      priorityPtr <= flowIdx_t'(`FLOW_NUM_FLOWS - 1);
    end else if (enablePriorityUpdate && anyWinner) begin
      priorityPtr <= winner;
    end
  end

endmodule : rr_arbiter

//--- testbench/flow_mux_tb.sv
// Testbench for the flow mux top with round-robin reference and pop-side checker

`include "flow_mux_defs.svh"

module flow_mux_tb
  import arb_types_pkg::*;
  import flow_types_pkg::*;
;

  // ------------------------------------------------------------------------
  // Run length
  // ------------------------------------------------------------------------

  // Single flow, all flows steady, then random traffic
  localparam int SingleItems    = 12;
  localparam int SteadyPerFlow  = 8;
  localparam int RandomPerFlow  = 40;
  localparam int TotalItems     = SingleItems + (SteadyPerFlow + RandomPerFlow) * `FLOW_NUM_FLOWS;
  localparam int WatchdogCycles = TotalItems * 20 + 300;

  // ------------------------------------------------------------------------
  // DUT signals
  // ------------------------------------------------------------------------

  logic            clk = 1'b0;
  logic            arstN;
  flowVec_t        pushValid = '0;
  flowVec_t        pushReady;
  flowPayloadVec_t pushPayload = '0;
  logic            popValid;
  logic            popReady = 1'b0;
  popItem_t        popItem;

  // Stimulus control, owned by the main sequence
  int   quota [`FLOW_NUM_FLOWS];
  int   plannedItems;
  logic randomValid;
  logic randomReady;

  // Driver bookkeeping
  int                          presented [`FLOW_NUM_FLOWS];
  logic [`FLOW_DATA_WIDTH-1:0] dataCount = '0;
  logic [15:0]                 lfsrState = 16'd12700;

  // Checker state
  int       acceptCount [`FLOW_NUM_FLOWS];
  popItem_t expectQ [$];
  flowIdx_t rrPtr = flowIdx_t'(`FLOW_NUM_FLOWS - 1);
  logic     holdPending = 1'b0;
  popItem_t holdItem;
  int       pushCount = 0;
  int       popCount = 0;
  int       valueErrors = 0;

  flow_mux_top flow_mux_top_inst (
    .clk         (clk),
    .arstN       (arstN),
    .pushValid   (pushValid),
    .pushReady   (pushReady),
    .pushPayload (pushPayload),
    .popValid    (popValid),
    .popReady    (popReady),
    .popItem     (popItem)
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  // First valid flow after the last grant, wrapping around
  function automatic flowIdx_t roundRobinWinner(input flowIdx_t lastGrant, input flowVec_t valid);
    flowIdx_t idx;
    flowIdx_t found;
    logic     hit;
    idx   = lastGrant;
    found = lastGrant;
    hit   = 1'b0;
    repeat (`FLOW_NUM_FLOWS) begin
      if (int'(idx) == `FLOW_NUM_FLOWS - 1) begin
        idx = '0;
      end else begin
        idx = idx + 1'b1;
      end
      if (!hit && valid[idx]) begin
        hit   = 1'b1;
        found = idx;
      end
    end
    return found;
  endfunction

  function automatic flowVec_t flowBit(input flowIdx_t idx);
    flowVec_t v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  task automatic flagValue(input string what);
    valueErrors++;
    $display("[FAIL] t=%0t %s", $time, what);
  endtask

  // ------------------------------------------------------------------------
  // Push driver, falling edge
  // ------------------------------------------------------------------------

  // A flow keeps its item up until accepted, then offers the next one
  always @(negedge clk) begin
    logic offer;
    for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
      if (acceptCount[f] == presented[f]) begin
        pushValid[f] = 1'b0;
        if (presented[f] < quota[f]) begin
          offer = 1'b1;
          if (randomValid) begin
            offer = lfsrBit();
          end
          if (offer) begin
            pushValid[f]        = 1'b1;
            pushPayload[f].tag  = f[`FLOW_TAG_WIDTH-1:0];
            pushPayload[f].data = dataCount;
            dataCount++;
            presented[f]++;
          end
        end
      end
    end
    if (randomReady) begin
      popReady = lfsrBit();
    end else begin
      popReady = 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Checker, rising edge
  // ------------------------------------------------------------------------

  always @(posedge clk) begin
    flowIdx_t winner;
    popItem_t expected;
    flowVec_t accepted;
    flowVec_t readyExp;
    int       inFlight;
    if (arstN) begin
      // Items held in the two-entry pop stage before this edge
      inFlight = expectQ.size();

      // Held item must not move while stalled
      if (holdPending) begin
        if (!popValid) begin
          flagValue("popValid dropped before the pop transfer");
        end else if (popItem !== holdItem) begin
          flagValue($sformatf("popItem changed under back-pressure: %h -> %h",
                              holdItem, popItem));
        end
      end
      // Valid one cycle after the push transfer, low once the stage is empty
      if (popValid !== (inFlight != 0)) begin
        flagValue($sformatf("popValid %b with %0d items in flight", popValid, inFlight));
      end
      if (popValid && popReady && expectQ.size() > 0) begin
        expected = expectQ.pop_front();
        if (popItem.source !== expected.source) begin
          flagValue($sformatf("source %0d, expected %0d", popItem.source, expected.source));
        end
        if (popItem.payload !== expected.payload) begin
          flagValue($sformatf("payload %h, expected %h", popItem.payload, expected.payload));
        end
        popCount++;
      end
      holdPending = popValid && !popReady;
      holdItem    = popItem;

      // Push side, ready goes to the reference winner unless both entries are full
      accepted = pushValid & pushReady;
      readyExp = '0;
      if (pushValid != '0) begin
        winner = roundRobinWinner(rrPtr, pushValid);
        if (inFlight < 2) begin
          readyExp = flowBit(winner);
        end
      end
      if (pushReady !== readyExp) begin
        flagValue($sformatf("pushReady %b, expected %b", pushReady, readyExp));
      end
      if (accepted != '0) begin
        expected.source  = winner;
        expected.payload = pushPayload[winner];
        expectQ.push_back(expected);
        pushCount++;
        rrPtr = winner;
      end
      for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
        if (accepted[f]) begin
          acceptCount[f]++;
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------

  // Adds items for the flows in the mask, then waits until all are popped
  task automatic runPhase(input flowVec_t mask, input int perFlow,
                          input logic rndValid, input logic rndReady);
    @(posedge clk);
    randomValid = rndValid;
    randomReady = rndReady;
    for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
      if (mask[f]) begin
        quota[f]     += perFlow;
        plannedItems += perFlow;
      end
    end
    do begin
      @(negedge clk);
    end while (popCount < plannedItems);
  endtask

  initial begin
    int countErrors;
    countErrors  = 0;
    arstN        = 1'b0;
    randomValid  = 1'b0;
    randomReady  = 1'b0;
    plannedItems = 0;
    for (int f = 0; f < `FLOW_NUM_FLOWS; f++) begin
      quota[f] = 0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    // Idle, the checker flags any popValid
    repeat (10) @(posedge clk);

    runPhase(flowVec_t'(4'b0100), SingleItems, 1'b0, 1'b0);
    runPhase('1, SteadyPerFlow, 1'b0, 1'b0);
    runPhase('1, RandomPerFlow, 1'b1, 1'b1);

    // Nothing stray may follow the last pop
    repeat (5) @(negedge clk);
    if (pushCount != popCount || pushCount != TotalItems) begin
      countErrors++;
      $display("Item count is wrong: %0d pushed, %0d popped, %0d planned",
               pushCount, popCount, TotalItems);
    end
    if (expectQ.size() != 0) begin
      countErrors++;
      $display("%0d expected items were never popped", expectQ.size());
    end
    $display("Errors: %0d value, %0d count; items %0d pushed, %0d popped",
             valueErrors, countErrors, pushCount, popCount);
    if (valueErrors + countErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // ------------------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------------------

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
    $display("test failed");
    $finish;
  end

endmodule : flow_mux_tb
